// File: logic/clock_pkg.sv
/*
 * clock package
 * shared enums, time and control structs, field limits and the segment table
 */
package clock_pkg;

	// ------------------------------------------------------------------------
	// modes and edit position
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,	// free-running count
		MODE_SETUP = 2'd1,	// count stopped, step edits clock time
		MODE_ALARM = 2'd2	// shows and edits alarm time
	} mode_e;

	typedef enum logic {
		POS_SEC = 1'b0,
		POS_MIN = 1'b1
	} pos_e;

	// ------------------------------------------------------------------------
	// time and control bundles
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [5:0] minutes;	// 0..59
		logic [5:0] seconds;	// 0..59
	} mm_ss_t;

	typedef struct packed {
		mode_e mode;
		pos_e  position;
		logic  alarm_en;	// level, toggled by the alarm key
		logic  step;		// one-cycle increment strobe
	} ctrl_t;

	// key indices into the key vector
	localparam int N_KEYS    = 4;
	localparam int KEY_MODE  = 0;
	localparam int KEY_POS   = 1;
	localparam int KEY_STEP  = 2;
	localparam int KEY_ALARM = 3;

	localparam logic [5:0] MAX_MS = 6'd59;	// last value of a field

	localparam int N_DIGITS = 4;

	typedef logic [6:0] seg_t;			// a in bit 6, g in bit 0
	typedef logic [N_DIGITS-1:0] digit_en_t;	// active low

	// hex to segments, active high
	localparam seg_t SEG_TABLE [16] = '{
		7'b111_1110,	// 0
		7'b011_0000,	// 1
		7'b110_1101,	// 2
		7'b111_1001,	// 3
		7'b011_0011,	// 4
		7'b101_1011,	// 5
		7'b101_1111,	// 6
		7'b111_0000,	// 7
		7'b111_1111,	// 8
		7'b111_0011,	// 9
		7'b111_0111,	// A
		7'b001_1111,	// b
		7'b100_1110,	// C
		7'b011_1101,	// d
		7'b100_1111,	// E
		7'b100_0111	// F
	};

endpackage

// File: logic/tick_gen.sv
/*
 * tick generator
 * one-cycle strobe every DIV clocks, first strobe DIV cycles after reset
 */
module tick_gen #(
	parameter int DIV = 4
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == CW'(DIV - 1)) begin
			cnt    <= '0;	// restart the period
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

// File: logic/key_debounce.sv
/*
 * key debouncer
 * two samples per key on i_sample, one press strobe per stable press
 */
module key_debounce #(
	parameter int N_KEYS = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_sample,
	input  logic [N_KEYS-1:0] i_keys,
	output logic [N_KEYS-1:0] o_press
);

	logic [N_KEYS-1:0] samp_new;	// latest sample
	logic [N_KEYS-1:0] samp_old;	// sample before that
	logic [N_KEYS-1:0] stable;	// debounced level

	// keys count as held out of reset, so a key held through
	// reset has to be released before it can press
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp_new <= '1;
			samp_old <= '1;
		end else if (i_sample) begin
			samp_new <= i_keys;
			samp_old <= samp_new;
		end
	end

	// ------------------------------------------------------------------------
	// stable level, set on press and cleared on two low samples
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stable <= '1;
		end else begin
			stable <= (stable | o_press) & (samp_new | samp_old);
		end
	end

	// high for the one cycle before stable catches up
	assign o_press = samp_new & samp_old & ~stable;

endmodule

// File: logic/mode_ctrl.sv
/*
 * mode controller
 * mode, edit position and alarm enable from key presses, plus the step strobe
 */
module mode_ctrl (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [clock_pkg::N_KEYS-1:0] i_press,
	output clock_pkg::ctrl_t             o_ctrl
);

	clock_pkg::mode_e mode;
	clock_pkg::pos_e  position;
	logic             alarm_en;
	logic             step;
	logic             edit_mode;	// step allowed here

	assign edit_mode = (mode == clock_pkg::MODE_SETUP) ||
			   (mode == clock_pkg::MODE_ALARM);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode     <= clock_pkg::MODE_CLOCK;
			position <= clock_pkg::POS_SEC;
			alarm_en <= 1'b0;
			step     <= 1'b0;
		end else begin
			if (i_press[clock_pkg::KEY_MODE]) begin
				if (mode == clock_pkg::MODE_ALARM)
					mode <= clock_pkg::MODE_CLOCK;	// wrap
				else
					mode <= clock_pkg::mode_e'(mode + 2'd1);
			end

			if (i_press[clock_pkg::KEY_POS]) begin
				position <= (position == clock_pkg::POS_SEC) ?
					    clock_pkg::POS_MIN : clock_pkg::POS_SEC;
			end

			if (i_press[clock_pkg::KEY_ALARM])
				alarm_en <= ~alarm_en;

			// one cycle copy of the step press
			step <= i_press[clock_pkg::KEY_STEP] & edit_mode;
		end
	end

	assign o_ctrl.mode     = mode;
	assign o_ctrl.position = position;
	assign o_ctrl.alarm_en = alarm_en;
	assign o_ctrl.step     = step;

endmodule

// File: logic/time_core.sv
/*
 * time core
 * clock and alarm minutes:seconds, setup stepping and the alarm flag
 */
module time_core (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_sec_tick,
	input  clock_pkg::ctrl_t  i_ctrl,
	output clock_pkg::mm_ss_t o_shown,
	output logic              o_alarm
);

	clock_pkg::mm_ss_t clk_time;	// running clock
	clock_pkg::mm_ss_t alm_time;	// alarm setting
	logic              run;		// count allowed
	logic              step_clk;	// step goes to clock time
	logic              step_alm;	// step goes to alarm time
	logic              match;
	logic              alarm_q;

	// field + 1, back to zero past 59
	function automatic logic [5:0] wrap_inc(input logic [5:0] v);
		return (v == clock_pkg::MAX_MS) ? 6'd0 : v + 6'd1;
	endfunction

	assign run      = i_sec_tick && (i_ctrl.mode != clock_pkg::MODE_SETUP);
	assign step_clk = i_ctrl.step && (i_ctrl.mode == clock_pkg::MODE_SETUP);
	assign step_alm = i_ctrl.step && (i_ctrl.mode != clock_pkg::MODE_SETUP);

	// ------------------------------------------------------------------------
	// clock time
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_time <= '0;
		end else if (run) begin
			if (clk_time.seconds == clock_pkg::MAX_MS) begin
				clk_time.seconds <= 6'd0;
				clk_time.minutes <= wrap_inc(clk_time.minutes);	// carry
			end else begin
				clk_time.seconds <= clk_time.seconds + 6'd1;
			end
		end else if (step_clk) begin
			// setup edit, no carry between fields
			if (i_ctrl.position == clock_pkg::POS_SEC)
				clk_time.seconds <= wrap_inc(clk_time.seconds);
			else
				clk_time.minutes <= wrap_inc(clk_time.minutes);
		end
	end

	// ------------------------------------------------------------------------
	// alarm time
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alm_time <= '0;
		end else if (step_alm) begin
			if (i_ctrl.position == clock_pkg::POS_SEC)
				alm_time.seconds <= wrap_inc(alm_time.seconds);
			else
				alm_time.minutes <= wrap_inc(alm_time.minutes);
		end
	end

	// ------------------------------------------------------------------------
	// alarm flag
	// ------------------------------------------------------------------------
	assign match = (clk_time == alm_time);

	// latches on a match, held until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_q <= 1'b0;
		end else begin
			alarm_q <= i_ctrl.alarm_en & (alarm_q | match);
		end
	end

	assign o_alarm = alarm_q;

	// alarm mode shows the alarm setting
	assign o_shown = (i_ctrl.mode == clock_pkg::MODE_ALARM) ? alm_time : clk_time;

endmodule

// File: logic/seg_display.sv
/*
 * seven-segment display driver
 * splits mm:ss into four digits and scans them one at a time
 */
module seg_display (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_scan_tick,
	input  clock_pkg::mm_ss_t    i_shown,
	output clock_pkg::seg_t      o_seg,
	output clock_pkg::digit_en_t o_digit_en
);

	localparam int IW = $clog2(clock_pkg::N_DIGITS);

	logic [IW-1:0] idx;		// digit being driven
	logic [5:0]    sec_tens;
	logic [5:0]    sec_units;
	logic [5:0]    min_tens;
	logic [5:0]    min_units;
	logic [3:0]    digits [clock_pkg::N_DIGITS];

	// ------------------------------------------------------------------------
	// tens and units split
	// ------------------------------------------------------------------------
	assign sec_tens  = i_shown.seconds / 6'd10;
	assign sec_units = i_shown.seconds % 6'd10;
	assign min_tens  = i_shown.minutes / 6'd10;
	assign min_units = i_shown.minutes % 6'd10;

	// digit 0 is the rightmost
	assign digits[0] = sec_units[3:0];
	assign digits[1] = sec_tens[3:0];
	assign digits[2] = min_units[3:0];
	assign digits[3] = min_tens[3:0];

	// ------------------------------------------------------------------------
	// scan index
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (i_scan_tick) begin
			if (idx == IW'(clock_pkg::N_DIGITS - 1))
				idx <= '0;	// back to digit 0
			else
				idx <= idx + 1'b1;
		end
	end

	// one low enable, pattern of that digit
	assign o_digit_en = ~(clock_pkg::digit_en_t'(1) << idx);
	assign o_seg      = clock_pkg::SEG_TABLE[digits[idx]];

endmodule

// File: logic/clock_top.sv
/*
 * minutes:seconds clock top level
 * strobe generators, key debounce, mode control, time core and display scan
 */
module clock_top #(
	parameter int TICK_DIV   = 50_000_000,	// one second
	parameter int SCAN_DIV   = 50_000,	// digit scan period
	parameter int SAMPLE_DIV = 500_000	// key sample period
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [clock_pkg::N_KEYS-1:0] i_keys,
	output clock_pkg::seg_t              o_seg,
	output clock_pkg::digit_en_t         o_digit_en,
	output clock_pkg::mm_ss_t            o_shown,
	output logic                         o_alarm
);

	logic                         sec_tick;
	logic                         scan_tick;
	logic                         sample_tick;
	logic [clock_pkg::N_KEYS-1:0] press;
	clock_pkg::ctrl_t             ctrl;

	// ------------------------------------------------------------------------
	// strobes
	// ------------------------------------------------------------------------
	tick_gen #(.DIV(TICK_DIV)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	tick_gen #(.DIV(SAMPLE_DIV)) u_sample_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sample_tick)
	);

	// ------------------------------------------------------------------------
	// keys to control
	// ------------------------------------------------------------------------
	key_debounce #(.N_KEYS(clock_pkg::N_KEYS)) u_key_debounce (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sample (sample_tick),
		.i_keys   (i_keys),
		.o_press  (press)
	);

	mode_ctrl u_mode_ctrl (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_press (press),
		.o_ctrl  (ctrl)
	);

	// ------------------------------------------------------------------------
	// time and display
	// ------------------------------------------------------------------------
	time_core u_time_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sec_tick (sec_tick),
		.i_ctrl     (ctrl),
		.o_shown    (o_shown),
		.o_alarm    (o_alarm)
	);

	seg_display u_seg_display (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_shown     (o_shown),
		.o_seg       (o_seg),
		.o_digit_en  (o_digit_en)
	);

endmodule

// File: test/clock_top_asserts.sv
/*
 * clock assertions
 * digit enable, field range and alarm enable checks for time_core and seg_display
 */
module clock_top_asserts #(
	parameter bit DISPLAY = 1'b0	// bound into the display driver
) (
	input logic                 clk,
	input logic                 rst_n,
	input clock_pkg::digit_en_t i_digit_en,
	input clock_pkg::mm_ss_t    i_time_a,
	input clock_pkg::mm_ss_t    i_time_b,
	input logic                 i_alarm,
	input logic                 i_alarm_en
);
	timeunit 1ns;
	timeprecision 100ps;

	if (DISPLAY) begin : g_display
		one_digit_low: assert property (@(posedge clk) disable iff (!rst_n)
			$onehot(~i_digit_en))
			else $error("digit enable does not have exactly one low bit");
	end else begin : g_time
		fields_in_range: assert property (@(posedge clk) disable iff (!rst_n)
			i_time_a.minutes <= clock_pkg::MAX_MS && i_time_a.seconds <= clock_pkg::MAX_MS &&
			i_time_b.minutes <= clock_pkg::MAX_MS && i_time_b.seconds <= clock_pkg::MAX_MS)
			else $error("time field above 59");

		// flag drops the cycle after the enable clears
		alarm_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
			!i_alarm_en |=> !i_alarm)
			else $error("alarm flag high without alarm enable");
	end

endmodule

bind time_core clock_top_asserts #(.DISPLAY(1'b0)) u_time_asserts (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_digit_en (),
	.i_time_a   (clk_time),
	.i_time_b   (alm_time),
	.i_alarm    (o_alarm),
	.i_alarm_en (i_ctrl.alarm_en)
);

bind seg_display clock_top_asserts #(.DISPLAY(1'b1)) u_seg_asserts (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_digit_en (o_digit_en),
	.i_time_a   (),
	.i_time_b   (),
	.i_alarm    (),
	.i_alarm_en ()
);

// File: test/tb_clock_top.sv
/*
 * clock_top testbench
 * directed tests for reset, counting, setup, alarm and display scan
 */
module tb_clock_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TICK_DIV    = 20;
	localparam int SCAN_DIV    = 4;
	localparam int SAMPLE_DIV  = 2;
	localparam int CLK_NS      = 4;
	localparam int PRESS_CYC   = 16 * SAMPLE_DIV;	// 8 samples held, 8 released
	localparam int MAX_PRESSES = 330;
	// count, setup freeze, alarm wait, key presses and a margin, in tick periods
	localparam int RUN_TICKS = 66 + 3 + 12 + MAX_PRESSES * PRESS_CYC / TICK_DIV + 50;

	logic                         clk;
	logic                         rst_n;
	logic [clock_pkg::N_KEYS-1:0] keys;
	clock_pkg::seg_t              seg;
	clock_pkg::digit_en_t         digit_en;
	clock_pkg::mm_ss_t            shown;
	logic                         alarm;
	int unsigned                  cyc;	// posedges since reset release

	clock_top #(
		.TICK_DIV   (TICK_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_keys     (keys),
		.o_seg      (seg),
		.o_digit_en (digit_en),
		.o_shown    (shown),
		.o_alarm    (alarm)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cyc <= 0;
		else
			cyc <= cyc + 1;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
			$display("Finished with errors");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_time(input clock_pkg::mm_ss_t exp);
		check("o_shown.minutes", shown.minutes, exp.minutes);
		check("o_shown.seconds", shown.seconds, exp.seconds);
	endtask

	function automatic clock_pkg::mm_ss_t to_mm_ss(input int secs);
		clock_pkg::mm_ss_t t;
		t.minutes = (secs / 60) % 60;
		t.seconds = secs % 60;
		return t;
	endfunction

	task automatic wait_until(input int unsigned target);
		while (cyc < target)
			@(negedge clk);
	endtask

	task automatic press_key(input int key);
		keys[key] = 1'b1;
		repeat (8 * SAMPLE_DIV) @(negedge clk);
		keys[key] = 1'b0;
		repeat (8 * SAMPLE_DIV) @(negedge clk);
	endtask

	task automatic step_field(input int n);
		repeat (n) press_key(clock_pkg::KEY_STEP);
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------
	task automatic reset_state;
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check("o_alarm", alarm, 0);
		check_time(to_mm_ss(0));
		check("o_digit_en", digit_en, 4'b1110);
	endtask

	// one second per TICK_DIV cycles, past the 00:59 carry
	task automatic count_seconds;
		for (int k = 1; k <= 66; k++) begin
			wait_until(k * TICK_DIV);
			check_time(to_mm_ss(k - 1));
			wait_until(k * TICK_DIV + 1);
			check_time(to_mm_ss(k));
		end
	endtask

	task automatic setup_edit;
		clock_pkg::mm_ss_t exp;
		int                n_sec;
		int                n_min;
		n_sec = $urandom_range(70, 1);
		n_min = $urandom_range(70, 1);
		press_key(clock_pkg::KEY_MODE);	// clock to setup
		exp = shown;
		repeat (3 * TICK_DIV) @(negedge clk);
		check_time(exp);	// frozen
		step_field(n_sec);
		exp.seconds = (exp.seconds + n_sec) % 60;
		check_time(exp);
		press_key(clock_pkg::KEY_POS);
		step_field(n_min);
		exp.minutes = (exp.minutes + n_min) % 60;
		check_time(exp);
		press_key(clock_pkg::KEY_POS);	// back to seconds
	endtask

	task automatic alarm_match;
		clock_pkg::mm_ss_t alm;
		clock_pkg::mm_ss_t start;
		clock_pkg::mm_ss_t now;
		int                lead;
		int                waited;
		alm.minutes = $urandom_range(3, 0);
		alm.seconds = $urandom_range(40, 20);
		lead = $urandom_range(9, 6);	// seconds from clock start to match
		start.minutes = alm.minutes;
		start.seconds = alm.seconds - lead;

		// alarm time starts from 00:00
		press_key(clock_pkg::KEY_MODE);	// setup to alarm
		step_field(alm.seconds);
		press_key(clock_pkg::KEY_POS);
		step_field(alm.minutes);
		press_key(clock_pkg::KEY_POS);
		check_time(alm);

		// through clock mode into setup, clock stops there
		press_key(clock_pkg::KEY_MODE);
		press_key(clock_pkg::KEY_MODE);
		now = shown;
		step_field((start.seconds - now.seconds + 60) % 60);
		press_key(clock_pkg::KEY_POS);
		step_field((start.minutes - now.minutes + 60) % 60);
		press_key(clock_pkg::KEY_POS);
		check_time(start);

		press_key(clock_pkg::KEY_ALARM);	// enable
		press_key(clock_pkg::KEY_MODE);	// clock runs again
		press_key(clock_pkg::KEY_MODE);	// back to clock mode

		waited = 0;
		while (shown !== alm && waited <= (lead + 2) * TICK_DIV) begin
			check("o_alarm", alarm, 0);
			waited++;
			@(negedge clk);
		end
		if (shown !== alm) begin
			$display("clock never reached the alarm time %0d:%0d", alm.minutes, alm.seconds);
			$display("Finished with errors");
			$fatal(1, "alarm time not reached");
		end
		check("o_alarm", alarm, 0);	// match cycle itself
		@(negedge clk);
		check("o_alarm", alarm, 1);
		repeat (TICK_DIV) @(negedge clk);
		check("o_alarm", alarm, 1);	// held past the match
		press_key(clock_pkg::KEY_ALARM);	// disable
		check("o_alarm", alarm, 0);
	endtask

	task automatic digit_scan;
		logic [clock_pkg::N_DIGITS-1:0] seen;
		int                             idx;
		int                             digit;
		seen = '0;
		repeat (4 * SCAN_DIV) begin
			@(negedge clk);
			check("o_digit_en low bits", $countones(~digit_en), 1);
			idx = 0;
			for (int i = 0; i < clock_pkg::N_DIGITS; i++) begin
				if (!digit_en[i])
					idx = i;
			end
			case (idx)
				0:       digit = shown.seconds % 10;
				1:       digit = shown.seconds / 10;
				2:       digit = shown.minutes % 10;
				default: digit = shown.minutes / 10;
			endcase
			check("o_seg", seg, clock_pkg::SEG_TABLE[digit]);
			seen[idx] = 1'b1;
		end
		check("digits scanned", seen, 4'hf);
	endtask

	// watchdog
	initial begin
		#(RUN_TICKS * TICK_DIV * CLK_NS);
		$display("run timed out after %0d tick periods", RUN_TICKS);
		$display("Finished with errors");
		$fatal(1, "timeout");
	end

	initial begin
		void'($urandom(32'h3ef4));
		rst_n = 1'b0;
		keys  = '0;
		reset_state();
		count_seconds();
		setup_edit();
		alarm_match();
		digit_scan();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: project.f
logic/clock_pkg.sv
logic/tick_gen.sv
logic/key_debounce.sv
logic/mode_ctrl.sv
logic/time_core.sv
logic/seg_display.sv
logic/clock_top.sv
test/clock_top_asserts.sv
test/tb_clock_top.sv
